// File: build.f
rom_map_pkg.sv
sdram_bus_pkg.sv
ready_timer.sv
rom_slot.sv
rom_arbiter_fsm.sv
rom_fetch_top.sv
tb_sdram_model.sv
tb_rom_fetch.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_rom_fetch
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "NO ERRORS" $(LOG) || (echo "simulation failed" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_rom_fetch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ROM fetch testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module tb_rom_fetch;
    import rom_map_pkg::*, sdram_bus_pkg::*;

    localparam int NUM_TXN     = 400;
    localparam int RESET_LEN   = 16;
    localparam int CYCLE_LIMIT = NUM_TXN * 40 + RESET_LEN;

    logic        clk;
    logic        reset;
    logic        downloading;
    logic        ready;
    client_req_t req_arr [NUM_CLIENTS];
    client_rsp_t rsp_arr [NUM_CLIENTS];
    wb_m2s_t     wb_o;
    wb_s2m_t     wb_i;

    int                   seed = 32'h1aab;
    int                   cycles = 0;
    int                   bus_count = 0;
    logic [SDRAM_AW-1:0]  adr_log [$];
    logic                 tb_valid [NUM_CLIENTS];
    logic [SDRAM_AW-1:0]  tb_word [NUM_CLIENTS];
    logic [CLIENT_AW-1:0] last_addr [NUM_CLIENTS];
    logic                 prev_cyc;
    logic                 prev_stb;
    logic                 prev_ack;
    logic                 prev_dl;
    logic [SDRAM_AW-1:0]  prev_adr;

    rom_fetch_top dut0 (
        .clk(clk), .reset(reset), .downloading(downloading),
        .main_req(req_arr[CL_MAIN]), .snd_req(req_arr[CL_SND]),
        .char_req(req_arr[CL_CHAR]), .obj_req(req_arr[CL_OBJ]),
        .main_rsp(rsp_arr[CL_MAIN]), .snd_rsp(rsp_arr[CL_SND]),
        .char_rsp(rsp_arr[CL_CHAR]), .obj_rsp(rsp_arr[CL_OBJ]),
        .wb_o(wb_o), .wb_i(wb_i), .ready(ready)
    );

    tb_sdram_model sdram0 (.clk(clk), .reset(reset), .bus_i(wb_o), .bus_o(wb_i));

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $fatal(1, "simulation stopped by timeout");
        end
    end

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s (got %h, expected %h)", $time, msg, actual,
                     expected);
            $display("ERRORS FOUND");
            $fatal(1, "check failed");
        end
    endtask

    // reference rom contents, same rule as the sdram image
    function automatic logic [31:0] ref_word(input logic [SDRAM_AW-1:0] adr);
        logic [31:0] x;
        logic [4:0]  sh;
        x  = {{(32 - SDRAM_AW){1'b0}}, adr} ^ 32'h5a3c_96e1;
        sh = adr[4:0];
        return (x << sh) | (x >> (32 - sh));
    endfunction

    function automatic logic is_byte_client(input int c);
        return (c == CL_SND) || (c == CL_MAIN);
    endfunction

    function automatic logic [SDRAM_AW-1:0] region_of(input int c);
        case (c)
            CL_SND:  return 22'h10000;
            CL_OBJ:  return 22'h20000;
            CL_CHAR: return 22'h14000;
            default: return 22'h00000;
        endcase
    endfunction

    function automatic logic [SDRAM_AW-1:0] word_of(input int c,
                                                    input logic [CLIENT_AW-1:0] addr);
        if (is_byte_client(c))
            return region_of(c) + SDRAM_AW'(addr >> 2);
        return region_of(c) + SDRAM_AW'(addr >> 1);
    endfunction

    function automatic logic [15:0] expected_data(input int c,
                                                  input logic [CLIENT_AW-1:0] addr);
        logic [31:0] w;
        w = ref_word(word_of(c, addr));
        if (is_byte_client(c))
            return {8'h00, w[8 * addr[1:0] +: 8]};
        return w[16 * addr[0] +: 16];
    endfunction

    // bus monitor, counts cycles and holds adr steady until ack
    always @(negedge clk) begin
        if (reset) begin
            prev_cyc <= 1'b0;
            prev_stb <= 1'b0;
        end else begin
            if (wb_o.cyc && !prev_cyc) begin
                bus_count = bus_count + 1;
                adr_log.push_back(wb_o.adr);
            end
            if (wb_o.cyc)
                check(wb_o.we, 1'b0, "write strobe on a read-only bus");
            if (prev_stb && !prev_ack && !prev_dl) begin
                check(wb_o.stb, 1'b1, "stb dropped before ack");
                check(wb_o.adr, prev_adr, "adr changed before ack");
            end
            prev_cyc <= wb_o.cyc;
            prev_stb <= wb_o.stb;
            prev_ack <= wb_i.ack;
            prev_dl  <= downloading;
            prev_adr <= wb_o.adr;
        end
    end

    // entered right after the edge that releases the hold
    task automatic measure_ready();
        int n;
        n = 0;
        @(negedge clk);
        check(wb_o.cyc, 1'b0, "cyc high during hold-off");
        check(wb_o.stb, 1'b0, "stb high during hold-off");
        while (!ready) begin
            @(posedge clk);
            n++;
            @(negedge clk);
        end
        check(n, READY_CYCLES, "ready delay");
    endtask

    task automatic do_read(input int c, input logic [CLIENT_AW-1:0] addr);
        logic [SDRAM_AW-1:0] w;
        logic                expect_hit;
        int                  start_bus;
        w          = word_of(c, addr);
        expect_hit = tb_valid[c] && (tb_word[c] == w);
        start_bus  = bus_count;
        @(posedge clk);
        req_arr[c] <= '{cs: 1'b1, addr: addr};
        do begin
            @(posedge clk);
            @(negedge clk);
            if (expect_hit)
                check(wb_o.cyc, 1'b0, "bus cycle on a cache hit");
        end while (!rsp_arr[c].ok);
        check(rsp_arr[c].data, expected_data(c, addr), $sformatf("client %0d data", c));
        check(bus_count - start_bus, expect_hit ? 0 : 1, "bus cycles for one read");
        tb_valid[c]  = 1'b1;
        tb_word[c]   = w;
        last_addr[c] = addr;
        @(posedge clk);
        req_arr[c].cs <= 1'b0;
    endtask

    // all four clients miss together, bus order must follow priority
    task automatic multi_miss();
        logic [CLIENT_AW-1:0] addr [NUM_CLIENTS];
        adr_log.delete();
        @(posedge clk);
        for (int c = 0; c < NUM_CLIENTS; c++) begin
            addr[c]    = last_addr[c] ^ 20'h00010; // always a different word
            req_arr[c] <= '{cs: 1'b1, addr: addr[c]};
        end
        do begin
            @(posedge clk);
            @(negedge clk);
        end while (!(rsp_arr[0].ok && rsp_arr[1].ok && rsp_arr[2].ok && rsp_arr[3].ok));
        check(adr_log.size(), 4, "bus cycles for four misses");
        for (int c = 0; c < NUM_CLIENTS; c++) begin
            check(adr_log[c], word_of(c, addr[c]), "priority order of adr");
            check(rsp_arr[c].data, expected_data(c, addr[c]), "data after shared miss");
            tb_valid[c]  = 1'b1;
            tb_word[c]   = word_of(c, addr[c]);
            last_addr[c] = addr[c];
        end
        @(posedge clk);
        for (int c = 0; c < NUM_CLIENTS; c++)
            req_arr[c].cs <= 1'b0;
    endtask

    task automatic download_check();
        @(posedge clk);
        req_arr[CL_MAIN] <= '{cs: 1'b1, addr: last_addr[CL_MAIN] ^ 20'h00010};
        do
            @(negedge clk);
        while (!wb_o.cyc);
        @(posedge clk);
        downloading          <= 1'b1;
        req_arr[CL_MAIN].cs  <= 1'b0;
        @(negedge clk);
        check(ready, 1'b0, "ready during download");
        @(posedge clk);
        @(negedge clk);
        check(wb_o.cyc, 1'b0, "bus cycle kept during download");
        repeat (3) @(posedge clk);
        @(posedge clk);
        downloading <= 1'b0;
        for (int c = 0; c < NUM_CLIENTS; c++)
            tb_valid[c] = 1'b0; // rom was rewritten
        measure_ready();
        for (int c = 0; c < NUM_CLIENTS; c++)
            do_read(c, last_addr[c]);
    endtask

    initial begin
        int                   c;
        logic [31:0]          r;
        logic [CLIENT_AW-1:0] addr;
        reset       = 1'b1;
        downloading = 1'b0;
        for (int i = 0; i < NUM_CLIENTS; i++) begin
            req_arr[i]   = '0;
            tb_valid[i]  = 1'b0;
            tb_word[i]   = '0;
            last_addr[i] = '0;
        end
        repeat (RESET_LEN - 1) @(posedge clk);
        @(posedge clk);
        reset <= 1'b0;
        measure_ready();
        for (int i = 0; i < NUM_CLIENTS; i++)
            check(rsp_arr[i].ok, 1'b0, "ok high after reset");

        for (int t = 0; t < NUM_TXN; t++) begin
            r = $random(seed);
            c = int'(r[1:0]);
            addr = CLIENT_AW'($random(seed));
            if (r[3:2] == 2'b00 && tb_valid[c])
                addr = {last_addr[c][CLIENT_AW-1:2], addr[1:0]}; // same word, maybe new lane
            do_read(c, addr);
            if (t == 100) begin
                for (int i = 0; i < NUM_CLIENTS; i++)
                    do_read(i, last_addr[i]); // repeat read hits
                multi_miss();
            end
        end
        download_check();

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_sdram_model.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone SDRAM slave model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module tb_sdram_model
    import rom_map_pkg::*, sdram_bus_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  wb_m2s_t bus_i,
    output wb_s2m_t bus_o
);

    int         seed = 32'h1aab;
    logic       busy;
    logic [2:0] wait_cnt;
    logic [2:0] delay;

    // rom contents follow from the word address
    function automatic logic [31:0] rom_word(input logic [SDRAM_AW-1:0] adr);
        logic [31:0] x;
        logic [4:0]  sh;
        x  = {{(32 - SDRAM_AW){1'b0}}, adr} ^ 32'h5a3c_96e1;
        sh = adr[4:0];
        return (x << sh) | (x >> (32 - sh));
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            bus_o    <= '0;
            busy     <= 1'b0;
            wait_cnt <= '0;
        end else if (bus_o.ack) begin
            bus_o.ack <= 1'b0; // one ack per cycle
        end else if (!(bus_i.cyc && bus_i.stb)) begin
            busy <= 1'b0; // master abandoned the cycle
        end else if (!busy) begin
            delay = 3'($random(seed));
            if (delay == 0) begin
                bus_o.ack <= 1'b1;
                bus_o.dat <= rom_word(bus_i.adr);
            end else begin
                busy     <= 1'b1;
                wait_cnt <= delay - 1'b1;
            end
        end else if (wait_cnt == 0) begin
            bus_o.ack <= 1'b1;
            bus_o.dat <= rom_word(bus_i.adr);
            busy      <= 1'b0;
        end else begin
            wait_cnt <= wait_cnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rom_fetch_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ROM fetch subsystem top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module rom_fetch_top
    import rom_map_pkg::*, sdram_bus_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        downloading,
    input  client_req_t main_req,
    input  client_req_t snd_req,
    input  client_req_t char_req,
    input  client_req_t obj_req,
    output client_rsp_t main_rsp,
    output client_rsp_t snd_rsp,
    output client_rsp_t char_rsp,
    output client_rsp_t obj_rsp,
    output wb_m2s_t     wb_o,
    input  wb_s2m_t     wb_i,
    output logic        ready
);

    logic [NUM_CLIENTS-1:0]               miss;
    logic [NUM_CLIENTS-1:0][SDRAM_AW-1:0] word_addrs;
    slot_fill_t                           fill;

    ready_timer u_timer (
        .clk(clk), .reset(reset), .downloading(downloading), .ready(ready)
    );

    // cpus read bytes, video layers read halves
    rom_slot #(.BYTE_WIDE(1'b1), .REGION_OFFSET(SND_OFFSET), .SLOT_INDEX(CL_SND)) u_snd (
        .clk(clk), .reset(reset), .downloading(downloading), .ready(ready),
        .req(snd_req), .rsp(snd_rsp), .miss(miss[CL_SND]),
        .word_addr(word_addrs[CL_SND]), .fill(fill)
    );

    rom_slot #(.BYTE_WIDE(1'b0), .REGION_OFFSET(OBJ_OFFSET), .SLOT_INDEX(CL_OBJ)) u_obj (
        .clk(clk), .reset(reset), .downloading(downloading), .ready(ready),
        .req(obj_req), .rsp(obj_rsp), .miss(miss[CL_OBJ]),
        .word_addr(word_addrs[CL_OBJ]), .fill(fill)
    );

    rom_slot #(.BYTE_WIDE(1'b0), .REGION_OFFSET(CHAR_OFFSET), .SLOT_INDEX(CL_CHAR)) u_char (
        .clk(clk), .reset(reset), .downloading(downloading), .ready(ready),
        .req(char_req), .rsp(char_rsp), .miss(miss[CL_CHAR]),
        .word_addr(word_addrs[CL_CHAR]), .fill(fill)
    );

    rom_slot #(.BYTE_WIDE(1'b1), .REGION_OFFSET(MAIN_OFFSET), .SLOT_INDEX(CL_MAIN)) u_main (
        .clk(clk), .reset(reset), .downloading(downloading), .ready(ready),
        .req(main_req), .rsp(main_rsp), .miss(miss[CL_MAIN]),
        .word_addr(word_addrs[CL_MAIN]), .fill(fill)
    );

    rom_arbiter_fsm u_arb (
        .clk(clk), .reset(reset), .downloading(downloading),
        .miss(miss), .word_addrs(word_addrs),
        .wb_o(wb_o), .wb_i(wb_i), .fill(fill)
    );

endmodule

`default_nettype wire

// File: rom_arbiter_fsm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ROM fetch arbiter FSM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module rom_arbiter_fsm
    import rom_map_pkg::*, sdram_bus_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 downloading,
    input  logic [NUM_CLIENTS-1:0]               miss,
    input  logic [NUM_CLIENTS-1:0][SDRAM_AW-1:0] word_addrs,
    output wb_m2s_t                              wb_o,
    input  wb_s2m_t                              wb_i,
    output slot_fill_t                           fill
);

    typedef enum logic [1:0] {
        IDLE,
        BUS,
        FILL
    } state_t;

    state_t               state;
    logic [CLIENT_IW-1:0] grant;
    logic [CLIENT_IW-1:0] pick;
    logic [SDRAM_AW-1:0]  adr_q;
    rom_word_u            rd_word;

    // fixed priority, lowest index wins
    always_comb begin
        pick = '0;
        for (int i = NUM_CLIENTS - 1; i >= 0; i--) begin
            if (miss[i])
                pick = CLIENT_IW'(i);
        end
    end

    always_ff @(posedge clk) begin
        if (reset || downloading) begin
            state <= IDLE; // drop any cycle in flight
        end else begin
            case (state)
                IDLE: begin
                    if (|miss)
                        state <= BUS;
                end
                BUS: begin
                    if (wb_i.ack)
                        state <= FILL;
                end
                FILL: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // grant and address are only loaded in IDLE so adr is stable in BUS
    always_ff @(posedge clk) begin
        if (state == IDLE && |miss) begin
            grant <= pick;
            adr_q <= word_addrs[pick];
        end
        if (state == BUS && wb_i.ack)
            rd_word <= wb_i.dat;
    end

    always_comb begin
        wb_o.cyc = (state == BUS);
        wb_o.stb = (state == BUS);
        wb_o.we  = 1'b0;
        wb_o.adr = adr_q;
    end

    always_comb begin
        fill.word = rd_word;
        if (state == FILL)
            fill.we = NUM_CLIENTS'(1) << grant;
        else
            fill.we = '0;
    end

    // classic handshake, request held unchanged until the slave acks
    a_adr_hold: assert property (@(posedge clk) disable iff (reset)
        wb_o.stb && !wb_i.ack && !downloading |=> wb_o.stb && $stable(wb_o.adr));

    a_fill_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(fill.we));

endmodule

`default_nettype wire

// File: rom_slot.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One-word ROM cache slot
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module rom_slot
    import rom_map_pkg::*, sdram_bus_pkg::*;
#(
    parameter bit                  BYTE_WIDE     = 1'b0,
    parameter logic [SDRAM_AW-1:0] REGION_OFFSET = '0,
    parameter int                  SLOT_INDEX    = 0
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                downloading,
    input  logic                ready,
    input  client_req_t         req,
    output client_rsp_t         rsp,
    output logic                miss,
    output logic [SDRAM_AW-1:0] word_addr,
    input  slot_fill_t          fill
);

    logic [SDRAM_AW-1:0] tag;
    logic                valid;
    rom_word_u           word;
    rom_word_u           src_word;
    logic [1:0]          lane;
    logic                hit;
    logic                fill_we;
    logic                ok_q;
    logic [15:0]         data_q;
    logic [15:0]         lane_data;

    assign fill_we = fill.we[SLOT_INDEX];

    // word address and lane from the client byte address
    always_comb begin
        if (BYTE_WIDE) begin
            word_addr = REGION_OFFSET + SDRAM_AW'(req.addr[CLIENT_AW-1:2]);
            lane      = req.addr[1:0];
        end else begin
            word_addr = REGION_OFFSET + SDRAM_AW'(req.addr[CLIENT_AW-1:1]);
            lane      = {1'b0, req.addr[0]};
        end
    end

    assign hit  = valid && (tag == word_addr);
    assign miss = req.cs && !hit && ready;

    // a fill is forwarded so ok follows the we pulse by one cycle
    assign src_word = fill_we ? fill.word : word;

    always_comb begin
        if (BYTE_WIDE)
            lane_data = {8'h00, src_word.bytes[lane]};
        else
            lane_data = src_word.halves[lane[0]];
    end

    always_ff @(posedge clk) begin
        if (reset || downloading) begin
            valid <= 1'b0; // download rewrites the rom
            ok_q  <= 1'b0;
        end else begin
            if (fill_we)
                valid <= 1'b1;
            ok_q <= req.cs && (hit || fill_we);
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we) begin
            word <= fill.word;
            tag  <= word_addr; // client holds its address until ok
        end
        data_q <= lane_data;
    end

    assign rsp = '{ok: ok_q, data: data_q};

    // arbiter only fills a slot that is still waiting for its word
    a_fill_on_miss: assert property (@(posedge clk) disable iff (reset || downloading)
        fill_we |-> miss);

endmodule

`default_nettype wire

// File: ready_timer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Start-up ready timer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module ready_timer
    import rom_map_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic downloading,
    output logic ready
);

    logic [READY_CW-1:0] cnt;
    logic                ready_q;

    always_ff @(posedge clk) begin
        if (reset || downloading) begin
            cnt     <= '0;
            ready_q <= 1'b0;
        end else begin
            if (cnt != READY_CW'(READY_CYCLES))
                cnt <= cnt + 1'b1; // stops at the limit
            ready_q <= (cnt >= READY_CW'(READY_CYCLES - 1));
        end
    end

    // no bus traffic in the cycle a download starts either
    assign ready = ready_q && !downloading;

    // full hold-off after every download
    a_hold_off: assert property (@(posedge clk) disable iff (reset)
        $fell(downloading) |-> !ready [*READY_CYCLES]);

endmodule

`default_nettype wire

// File: sdram_bus_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SDRAM and client bus types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package sdram_bus_pkg;
    import rom_map_pkg::*;

    // wishbone classic, master to slave
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;  // reads only, tied low
        logic [SDRAM_AW-1:0] adr;
    } wb_m2s_t;

    // wishbone classic, slave to master
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_s2m_t;

    typedef struct packed {
        logic                 cs;
        logic [CLIENT_AW-1:0] addr;
    } client_req_t;

    // byte clients see the upper byte as zero
    typedef struct packed {
        logic        ok;
        logic [15:0] data;
    } client_rsp_t;

    // one sdram word, byte view for cpus, half view for video
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } rom_word_u;

    typedef struct packed {
        rom_word_u              word;
        logic [NUM_CLIENTS-1:0] we; // one-hot slot select
    } slot_fill_t;

endpackage

`default_nettype wire

// File: rom_map_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ROM map constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package rom_map_pkg;

    // address widths
    localparam int CLIENT_AW = 20; // client byte address
    localparam int SDRAM_AW  = 22; // sdram 32-bit word address

    // clients, lower index wins arbitration
    localparam int NUM_CLIENTS = 4;
    localparam int CLIENT_IW   = 2; // width of a client index

    localparam logic [CLIENT_IW-1:0] CL_SND  = 2'd0;
    localparam logic [CLIENT_IW-1:0] CL_OBJ  = 2'd1;
    localparam logic [CLIENT_IW-1:0] CL_CHAR = 2'd2;
    localparam logic [CLIENT_IW-1:0] CL_MAIN = 2'd3;

    // region start of each client, in sdram words
    localparam logic [SDRAM_AW-1:0] MAIN_OFFSET = 22'h00000; // program rom
    localparam logic [SDRAM_AW-1:0] SND_OFFSET  = 22'h10000;
    localparam logic [SDRAM_AW-1:0] CHAR_OFFSET = 22'h14000;
    localparam logic [SDRAM_AW-1:0] OBJ_OFFSET  = 22'h20000; // sprite data

    // start-up hold off
    localparam int READY_CYCLES = 15;
    localparam int READY_CW     = 4; // must hold READY_CYCLES

endpackage

`default_nettype wire
